/* source/pov_pkg.sv */
`default_nettype none

/* Shared widths, opcodes, command lengths and timing constants of the POV display core
   Timing constants count clk cycles or enable ticks as named */

package pov_pkg;

    // Command and reply sizes
    localparam int cmd_width     = 64;
    localparam int cmd_len_width = 4;
    localparam int reply_width   = 48;

    // Driver data
    localparam int conf_width    = 48;
    localparam int pixel_width   = 30;
    localparam int channel_width = pixel_width / 3;
    localparam int sensor_width  = 16;

    // Frame shape and timing, in enable ticks
    localparam int column_words    = 2;
    localparam int blanking_ticks  = 72;
    localparam int enable_divider  = 4;
    localparam int conf_frame_bits = conf_width + 1;

    // Counter widths derived from the above
    localparam int enable_cnt_width = (enable_divider > 1) ? $clog2(enable_divider) : 1;
    localparam int drv_cnt_width =
        $clog2(((conf_width > blanking_ticks) ? conf_width : blanking_ticks) + 1);
    localparam int word_cnt_width = $clog2(column_words + 1);

    // Opcodes and their exact lengths in bytes
    localparam logic [7:0] op_set_conf    = 8'h01;
    localparam logic [7:0] op_rgb_enable  = 8'h02;
    localparam logic [7:0] op_read_status = 8'h03;
    localparam logic [cmd_len_width-1:0] len_set_conf    = 4'd7;
    localparam logic [cmd_len_width-1:0] len_rgb_enable  = 4'd2;
    localparam logic [cmd_len_width-1:0] len_read_status = 4'd1;

    typedef logic [cmd_width-1:0]   cmd_t;
    typedef logic [conf_width-1:0]  conf_t;
    typedef logic [pixel_width-1:0] pixel_t;

endpackage

`default_nettype wire

/* source/spi_slave.sv */
`default_nettype none

/* Mode 0 SPI slave with MSB first and spi_ss active low
   Each spi_clk half period must last at least 8 clk cycles
   Only the first 8 bytes are kept and the byte count saturates at 15 */

module spi_slave (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               spi_clk,
    input  logic                               spi_ss,
    input  logic                               spi_mosi,
    input  logic [pov_pkg::reply_width-1:0]    cmd_write,
    output logic                               spi_miso,
    output logic                               valid,
    output pov_pkg::cmd_t                      cmd_read,
    output logic [pov_pkg::cmd_len_width-1:0]  cmd_len_bytes
);
    import pov_pkg::*;

    // Two sync flops plus one history flop for edge detection
    logic [2:0] sclk_sync;
    logic [2:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_rise;
    logic       ss_fall;
    logic       ss_active;

    logic [2:0]             bit_cnt;
    logic [6:0]             byte_shift;
    logic [reply_width-1:0] reply_shift;
    logic                   reply_loaded;
    logic                   valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync <= '0;
            ss_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clk};
            ss_sync   <= {ss_sync[1:0], spi_ss};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign ss_rise   = ss_sync[1] & ~ss_sync[2];
    assign ss_fall   = ~ss_sync[1] & ss_sync[2];
    assign ss_active = ~ss_sync[1];

    // Bit and byte counting, framed by spi_ss
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt       <= '0;
            cmd_len_bytes <= '0;
            valid         <= 1'b0;
        end else begin
            // End of transaction, counts and command already stable
            valid <= ss_rise;
            if (ss_fall) begin
                bit_cnt       <= '0;
                cmd_len_bytes <= '0;
            end else if (ss_active && sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7 && cmd_len_bytes != '1) begin
                    cmd_len_bytes <= cmd_len_bytes + 1'b1;
                end
            end
        end
    end

    // Completed bytes go from the top byte downward
    always_ff @(posedge clk) begin
        if (ss_active && sclk_rise) begin
            byte_shift <= {byte_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7 && cmd_len_bytes < cmd_len_width'(cmd_width / 8)) begin
                cmd_read[cmd_width-1 - 8*cmd_len_bytes[2:0] -: 8] <= {byte_shift, mosi_sync[1]};
            end
        end
    end

    // Reload one cycle after valid so the decoder's answer is already in cmd_write
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q      <= 1'b0;
            reply_loaded <= 1'b0;
        end else begin
            valid_q <= valid;
            if (valid_q) begin
                reply_loaded <= 1'b1;
            end
        end
    end

    // Reply moves on falling spi_clk so the host samples a settled bit
    always_ff @(posedge clk) begin
        if (valid_q) begin
            reply_shift <= cmd_write;
        end else if (ss_active && sclk_fall) begin
            reply_shift <= {reply_shift[reply_width-2:0], 1'b0};
        end
    end

    assign spi_miso = reply_loaded & reply_shift[reply_width-1];

endmodule

`default_nettype wire

/* source/spi_decoder.sv */
`default_nettype none

/* Commands with an unknown opcode or a length other than the exact one are ignored
   Any command other than a good read-status clears the pending reply */

module spi_decoder (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               valid,
    input  pov_pkg::cmd_t                      cmd_read,
    input  logic [pov_pkg::cmd_len_width-1:0]  cmd_len_bytes,
    input  logic [pov_pkg::sensor_width-1:0]   rotation_data,
    input  logic [pov_pkg::sensor_width-1:0]   speed_data,
    output logic [pov_pkg::reply_width-1:0]    cmd_write,
    output pov_pkg::conf_t                     configuration,
    output logic                               new_config_available,
    output logic                               rgb_enable
);
    import pov_pkg::*;

    logic [7:0] opcode;
    logic       do_conf;
    logic       do_rgb;
    logic       do_status;

    // Opcode sits in the first received byte
    assign opcode    = cmd_read[cmd_width-1 -: 8];
    assign do_conf   = valid && opcode == op_set_conf    && cmd_len_bytes == len_set_conf;
    assign do_rgb    = valid && opcode == op_rgb_enable  && cmd_len_bytes == len_rgb_enable;
    assign do_status = valid && opcode == op_read_status && cmd_len_bytes == len_read_status;

    always_ff @(posedge clk) begin
        if (reset) begin
            new_config_available <= 1'b0;
            rgb_enable           <= 1'b0;
            cmd_write            <= '0;
        end else begin
            new_config_available <= do_conf;
            if (do_rgb) begin
                // Bit 0 of the byte after the opcode
                rgb_enable <= cmd_read[cmd_width-16];
            end
            if (do_status) begin
                cmd_write <= {rotation_data, speed_data,
                              {(reply_width - 2*sensor_width){1'b0}}};
            end else if (valid) begin
                cmd_write <= '0;
            end
        end
    end

    // Six bytes right below the opcode
    always_ff @(posedge clk) begin
        if (do_conf) begin
            configuration <= cmd_read[cmd_width-9 -: conf_width];
        end
    end

endmodule

`default_nettype wire

/* source/clock_enable.sv */
`default_nettype none

/* One clk wide pulse every enable_divider cycles
   First pulse comes enable_divider cycles after reset */

module clock_enable (
    input  logic clk,
    input  logic reset,
    output logic clk_enable
);
    import pov_pkg::*;

    logic [enable_cnt_width-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= '0;
            clk_enable <= 1'b0;
        end else if (count == enable_cnt_width'(enable_divider - 1)) begin
            // Wrap and fire
            count      <= '0;
            clk_enable <= 1'b1;
        end else begin
            count      <= count + 1'b1;
            clk_enable <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/framebuffer_emulator.sv */
`default_nettype none

/* Test pattern source standing in for the real framebuffer
   A word appears the cycle after word_req and holds until the next request */

module framebuffer_emulator (
    input  logic            clk,
    input  logic            reset,
    input  logic            word_req,
    output pov_pkg::pixel_t data
);
    import pov_pkg::*;

    // Pattern counter, wraps modulo 1024
    logic [channel_width-1:0] k;

    always_ff @(posedge clk) begin
        if (reset) begin
            k <= '0;
        end else if (word_req) begin
            k <= k + 1'b1;
        end
    end

    // Channels from top to bottom are k, inverted k, then k again
    always_ff @(posedge clk) begin
        if (word_req) begin
            data <= {k, ~k, k};
        end
    end

endmodule

`default_nettype wire

/* source/driver_controller.sv */
`default_nettype none

/* Serial LED driver stream on one data line, all timing in clk_enable ticks
   Config frames carry mode bit 1 and pixel frames mode bit 0 with column_words words
   Pixel payload is forced to zero while rgb_enable is clear */

module driver_controller (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    input  pov_pkg::pixel_t data,
    input  pov_pkg::conf_t  configuration,
    input  logic            new_config_available,
    input  logic            rgb_enable,
    output logic            word_req,
    output logic            driver_sclk,
    output logic            driver_sin,
    output logic            driver_lat,
    output logic            driver_blank
);
    import pov_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_latch,
        st_blank
    } state_t;

    state_t                     state;
    logic [conf_frame_bits-1:0] shift_reg;
    logic [drv_cnt_width-1:0]   cnt;
    logic [word_cnt_width-1:0]  words_left;
    logic                       conf_frame;
    logic                       conf_pending;
    logic                       start_conf;
    logic                       bit_done;

    assign start_conf = clk_enable && state == st_idle && conf_pending;
    // High phase ends at this tick
    assign bit_done   = clk_enable && state == st_shift && driver_sclk;
    assign driver_sin = shift_reg[conf_frame_bits-1];

    // Start wins since the decoder register already holds the newest copy
    always_ff @(posedge clk) begin
        if (reset) begin
            conf_pending <= 1'b0;
        end else if (start_conf) begin
            conf_pending <= 1'b0;
        end else if (new_config_available) begin
            conf_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            driver_sclk  <= 1'b0;
            driver_lat   <= 1'b0;
            driver_blank <= 1'b1;
            word_req     <= 1'b0;
            cnt          <= '0;
            words_left   <= '0;
            conf_frame   <= 1'b0;
        end else begin
            word_req <= 1'b0;
            if (clk_enable) begin
                case (state)
                    st_idle: begin
                        state      <= st_shift;
                        conf_frame <= conf_pending;
                        if (conf_pending) begin
                            // Mode bit plus 48 config bits
                            cnt        <= drv_cnt_width'(conf_width);
                            words_left <= '0;
                        end else begin
                            // Mode bit alone, first word fetched meanwhile
                            cnt        <= '0;
                            words_left <= word_cnt_width'(column_words);
                            word_req   <= 1'b1;
                        end
                    end
                    st_shift: begin
                        driver_sclk <= ~driver_sclk;
                        if (driver_sclk) begin
                            if (cnt != '0) begin
                                cnt <= cnt - 1'b1;
                            end else if (words_left != '0) begin
                                // Next word loads now, its successor is requested
                                cnt        <= drv_cnt_width'(pixel_width - 1);
                                words_left <= words_left - 1'b1;
                                if (words_left > word_cnt_width'(1)) begin
                                    word_req <= 1'b1;
                                end
                            end else begin
                                driver_lat <= 1'b1;
                                state      <= st_latch;
                            end
                        end
                    end
                    st_latch: begin
                        driver_lat <= 1'b0;
                        if (conf_frame) begin
                            state <= st_idle;
                        end else begin
                            driver_blank <= 1'b1;
                            cnt          <= drv_cnt_width'(blanking_ticks - 1);
                            state        <= st_blank;
                        end
                    end
                    st_blank: begin
                        if (cnt == '0) begin
                            driver_blank <= 1'b0;
                            state        <= st_idle;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // MSB first out of the top bit, shifted at each falling sclk
    always_ff @(posedge clk) begin
        if (clk_enable && state == st_idle) begin
            if (conf_pending) begin
                shift_reg <= {1'b1, configuration};
            end else begin
                shift_reg <= '0;
            end
        end else if (bit_done) begin
            if (cnt != '0) begin
                shift_reg <= {shift_reg[conf_frame_bits-2:0], 1'b0};
            end else if (words_left != '0) begin
                shift_reg <= {data & {pixel_width{rgb_enable}},
                              {(conf_frame_bits - pixel_width){1'b0}}};
            end
        end
    end

endmodule

`default_nettype wire

/* source/pov_display.sv */
`default_nettype none

/* Core of the POV display, position sync taken as always asserted
   Host must keep spi_clk half periods at least 8 clk cycles long */

module pov_display (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              spi_clk,
    input  logic                              spi_ss,
    input  logic                              spi_mosi,
    input  logic [pov_pkg::sensor_width-1:0]  rotation_data,
    input  logic [pov_pkg::sensor_width-1:0]  speed_data,
    output logic                              spi_miso,
    output logic                              driver_sclk,
    output logic                              driver_sin,
    output logic                              driver_lat,
    output logic                              driver_blank
);
    import pov_pkg::*;

    // SPI to decoder
    cmd_t                     cmd_read;
    logic [cmd_len_width-1:0] cmd_len_bytes;
    logic [reply_width-1:0]   cmd_write;
    logic                     valid;

    // Decoder to driver
    conf_t configuration;
    logic  new_config_available;
    logic  rgb_enable;

    // Tick and pixel handshake
    logic   clk_enable;
    logic   word_req;
    pixel_t pixel_data;

    spi_slave u_spi_slave (
        .clk           (clk),
        .reset         (reset),
        .spi_clk       (spi_clk),
        .spi_ss        (spi_ss),
        .spi_mosi      (spi_mosi),
        .cmd_write     (cmd_write),
        .spi_miso      (spi_miso),
        .valid         (valid),
        .cmd_read      (cmd_read),
        .cmd_len_bytes (cmd_len_bytes)
    );

    spi_decoder u_spi_decoder (
        .clk                  (clk),
        .reset                (reset),
        .valid                (valid),
        .cmd_read             (cmd_read),
        .cmd_len_bytes        (cmd_len_bytes),
        .rotation_data        (rotation_data),
        .speed_data           (speed_data),
        .cmd_write            (cmd_write),
        .configuration        (configuration),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable)
    );

    clock_enable u_clock_enable (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable)
    );

    framebuffer_emulator u_fb_emulator (
        .clk      (clk),
        .reset    (reset),
        .word_req (word_req),
        .data     (pixel_data)
    );

    driver_controller u_driver_controller (
        .clk                  (clk),
        .reset                (reset),
        .clk_enable           (clk_enable),
        .data                 (pixel_data),
        .configuration        (configuration),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable),
        .word_req             (word_req),
        .driver_sclk          (driver_sclk),
        .driver_sin           (driver_sin),
        .driver_lat           (driver_lat),
        .driver_blank         (driver_blank)
    );

endmodule

`default_nettype wire

/* tb/pov_display_tb.sv */
`default_nettype none

/* Random SPI commands against a model of the decoder, pattern source and frame format
   Host changes reach the DUT a few clk later, so words loaded near a change accept either value */

module pov_display_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pov_pkg::*;

    localparam int clk_period_ns = 4;
    localparam int reset_cycles  = 16;
    localparam int spi_half      = 10;
    localparam int cmd_gap       = 20;
    localparam int num_commands  = 80;
    localparam int max_cmd_bytes = 9;
    // Enough words to pass the 1024 wrap of the pattern counter
    localparam int wrap_words    = 1100;
    localparam real settle_ns    = 100.0;
    localparam real min_blank_ns = blanking_ticks * enable_divider * clk_period_ns;
    localparam int spi_cmd_clks  = (max_cmd_bytes * 16 + 4) * spi_half + cmd_gap;
    localparam int frame_clks    =
        ((1 + column_words * pixel_width) * 2 + 2 + blanking_ticks) * enable_divider;
    localparam int total_frames  = wrap_words / column_words + 8;
    localparam real timeout_ns   = 2.0 * clk_period_ns *
        (reset_cycles + num_commands * spi_cmd_clks + total_frames * frame_clks);

    logic                    clk;
    logic                    reset;
    logic                    spi_clk;
    logic                    spi_ss;
    logic                    spi_mosi;
    logic [sensor_width-1:0] rotation_data;
    logic [sensor_width-1:0] speed_data;
    logic                    spi_miso;
    logic                    driver_sclk;
    logic                    driver_sin;
    logic                    driver_lat;
    logic                    driver_blank;

    integer     seed        = 32'hde40_5048;
    int         error_count = 0;
    logic [7:0] tx_bytes [0:max_cmd_bytes-1];

    // Model of decoder state and pattern counter
    logic                     rgb_model        = 1'b0;
    real                      rgb_change_time  = -1000.0;
    conf_t                    conf_latest      = '0;
    conf_t                    conf_prev        = '0;
    real                      conf_change_time = -1000.0;
    int                       conf_seq         = 0;
    int                       conf_done_seq    = 0;
    logic [reply_width-1:0]   reply_model      = '0;
    logic [channel_width-1:0] pattern_k        = '0;
    int                       words_seen       = 0;
    int                       pixel_frames     = 0;

    // Frame monitor, snapshots taken at the rising sclk of mode bit and word starts
    logic  frame_bits [$];
    conf_t snap_conf;
    conf_t snap_prev;
    int    snap_seq;
    logic  snap_sure;
    logic  word_rgb  [column_words];
    logic  word_sure [column_words];
    logic  last_was_pixel  = 1'b0;
    logic  blank_armed     = 1'b0;
    real   lat_fall_time   = 0.0;
    real   blank_rise_time = 0.0;
    real   blank_fall_time = 0.0;

    pov_display u_dut (
        .clk           (clk),
        .reset         (reset),
        .spi_clk       (spi_clk),
        .spi_ss        (spi_ss),
        .spi_mosi      (spi_mosi),
        .rotation_data (rotation_data),
        .speed_data    (speed_data),
        .spi_miso      (spi_miso),
        .driver_sclk   (driver_sclk),
        .driver_sin    (driver_sin),
        .driver_lat    (driver_lat),
        .driver_blank  (driver_blank)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_conf(input string name, input conf_t expected, input conf_t actual);
        if (actual !== expected) begin
            error_count++;
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            error_count++;
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_reply(input string name, input logic [reply_width-1:0] expected,
                               input logic [reply_width-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            report_failure($sformatf("CHECK FAILED %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    // Channels k, inverted k, k from top to bottom
    function automatic pixel_t pattern_word(input logic [channel_width-1:0] k);
        return {k, ~k, k};
    endfunction

    // Called on a falling clk, returns on the falling clk that raised spi_ss
    task automatic spi_transfer(input int n_bytes, input string name);
        logic [reply_width-1:0] rx;
        logic [reply_width-1:0] mask;
        int                     nbit;
        int                     i;
        int                     b;
        rx     = '0;
        mask   = '0;
        nbit   = 0;
        spi_ss = 1'b0;
        repeat (spi_half) @(negedge clk);
        for (i = 0; i < n_bytes; i++) begin
            for (b = 7; b >= 0; b--) begin
                spi_mosi = tx_bytes[i][b];
                repeat (spi_half) @(negedge clk);
                spi_clk = 1'b1;
                // Reply bit settled since the last falling spi_clk
                if (nbit < reply_width) begin
                    rx[reply_width-1-nbit]   = spi_miso;
                    mask[reply_width-1-nbit] = 1'b1;
                end
                nbit++;
                repeat (spi_half) @(negedge clk);
                spi_clk = 1'b0;
            end
        end
        repeat (spi_half) @(negedge clk);
        spi_ss = 1'b1;
        check_reply(name, reply_model & mask, rx);
    endtask

    // Decoder rules: exact length per opcode, anything else ignored
    task automatic apply_model(input int n_bytes);
        logic [7:0] op;
        op          = tx_bytes[0];
        reply_model = '0;
        if (n_bytes == 7 && op == op_set_conf) begin
            conf_prev        = conf_latest;
            conf_latest      = {tx_bytes[1], tx_bytes[2], tx_bytes[3],
                                tx_bytes[4], tx_bytes[5], tx_bytes[6]};
            conf_seq++;
            conf_change_time = $realtime;
        end else if (n_bytes == 2 && op == op_rgb_enable) begin
            rgb_model       = tx_bytes[1][0];
            rgb_change_time = $realtime;
        end else if (n_bytes == 1 && op == op_read_status) begin
            reply_model = {rotation_data, speed_data, 16'h0000};
        end
    endtask

    task automatic random_command(output int n_bytes);
        int kind;
        int i;
        kind = $random(seed) & 7;
        for (i = 0; i < max_cmd_bytes; i++) begin
            tx_bytes[i] = 8'($random(seed));
        end
        case (kind)
            0, 1: begin
                tx_bytes[0] = op_set_conf;
                n_bytes     = 7;
            end
            2, 3: begin
                tx_bytes[0] = op_rgb_enable;
                n_bytes     = 2;
            end
            4, 5: begin
                tx_bytes[0] = op_read_status;
                n_bytes     = 1;
            end
            6: begin
                // Known opcode, wrong length
                tx_bytes[0] = 8'(1 + ($random(seed) & 3) % 3);
                n_bytes     = ($random(seed) & 15) % 10;
                if ((tx_bytes[0] == 8'd1 && n_bytes == 7) ||
                    (tx_bytes[0] == 8'd2 && n_bytes == 2) ||
                    (tx_bytes[0] == 8'd3 && n_bytes == 1)) begin
                    n_bytes = (n_bytes + 1) % 10;
                end
            end
            default: begin
                // Unknown opcode
                if (tx_bytes[0] >= 8'd1 && tx_bytes[0] <= 8'd3) begin
                    tx_bytes[0] = tx_bytes[0] + 8'h10;
                end
                n_bytes = 1 + ($random(seed) & 15) % 9;
            end
        endcase
    endtask

    task automatic process_frame();
        conf_t  conf_bits;
        pixel_t word;
        pixel_t expected;
        int     n;
        int     w;
        int     i;
        n              = frame_bits.size();
        last_was_pixel = 1'b0;
        if (n == conf_width + 1 && frame_bits[0] == 1'b1) begin
            for (i = 0; i < conf_width; i++) begin
                conf_bits[conf_width-1-i] = frame_bits[1+i];
            end
            if (snap_seq == conf_done_seq) begin
                report_failure("A configuration frame appeared with no configuration pending");
            end else if (!snap_sure && conf_bits == snap_prev && snap_seq - 1 > conf_done_seq) begin
                // Frame loaded just before the newest copy arrived
                conf_done_seq = snap_seq - 1;
            end else begin
                check_conf("configuration frame", snap_conf, conf_bits);
                conf_done_seq = snap_seq;
            end
        end else if (n == 1 + column_words * pixel_width && frame_bits[0] == 1'b0) begin
            for (w = 0; w < column_words; w++) begin
                for (i = 0; i < pixel_width; i++) begin
                    word[pixel_width-1-i] = frame_bits[1 + w*pixel_width + i];
                end
                expected = pattern_word(pattern_k);
                if (word_sure[w] && !word_rgb[w]) begin
                    expected = '0;
                end else if (!word_sure[w] && word == '0) begin
                    expected = '0;
                end
                check_pixel($sformatf("pixel word %0d", words_seen), expected, word);
                // Counter advances even when the payload is masked
                pattern_k = pattern_k + 1'b1;
                words_seen++;
            end
            pixel_frames++;
            last_was_pixel = 1'b1;
        end else begin
            report_failure($sformatf("A frame of %0d bits matches neither frame type", n));
        end
        frame_bits.delete();
    endtask

    always @(posedge driver_sclk) begin
        int  n;
        real held;
        frame_bits.push_back(driver_sin);
        n = frame_bits.size();
        if (n == 1) begin
            snap_conf = conf_latest;
            snap_prev = conf_prev;
            snap_seq  = conf_seq;
            snap_sure = ($realtime - conf_change_time) > settle_ns;
        end
        // First bit of each pixel word
        if (n >= 2 && (n - 2) % pixel_width == 0 && (n - 2) / pixel_width < column_words) begin
            word_rgb[(n - 2) / pixel_width]  = rgb_model;
            word_sure[(n - 2) / pixel_width] = ($realtime - rgb_change_time) > settle_ns;
        end
        if (blank_armed) begin
            blank_armed = 1'b0;
            held = driver_blank ? $realtime - lat_fall_time : blank_fall_time - lat_fall_time;
            if (blank_rise_time > lat_fall_time || held < min_blank_ns) begin
                report_failure($sformatf("driver_blank was not held high for %0.1f ns %s",
                                         min_blank_ns, "after a pixel latch"));
            end
        end
    end

    always @(posedge driver_lat) begin
        process_frame();
    end

    always @(negedge driver_lat) begin
        lat_fall_time = $realtime;
        blank_armed   = last_was_pixel;
    end

    always @(posedge driver_blank) begin
        blank_rise_time = $realtime;
    end

    always @(negedge driver_blank) begin
        blank_fall_time = $realtime;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        error_count++;
        report_failure("The simulation timed out before all tests finished");
    end

    initial begin
        int n;
        int c;
        clk           = 1'b0;
        reset         = 1'b1;
        spi_clk       = 1'b0;
        spi_ss        = 1'b1;
        spi_mosi      = 1'b0;
        rotation_data = sensor_width'($random(seed));
        speed_data    = sensor_width'($random(seed));
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit("driver_blank after reset", 1'b1, driver_blank);
        check_bit("driver_lat after reset", 1'b0, driver_lat);
        check_bit("spi_miso after reset", 1'b0, spi_miso);

        // Frames with rgb still clear
        wait (pixel_frames >= 2);
        @(negedge clk);

        for (c = 0; c < num_commands; c++) begin
            rotation_data = sensor_width'($random(seed));
            speed_data    = sensor_width'($random(seed));
            random_command(n);
            spi_transfer(n, $sformatf("reply during command %0d", c));
            apply_model(n);
            repeat (cmd_gap) @(negedge clk);
        end

        // Pattern on, then run the counter across its wrap
        tx_bytes[0] = op_rgb_enable;
        tx_bytes[1] = 8'h01;
        spi_transfer(2, "reply during final rgb enable");
        apply_model(2);
        wait (words_seen >= wrap_words);
        @(negedge clk);
        if (conf_seq != conf_done_seq) begin
            error_count++;
            report_failure("A configuration sent by the host never reached the drivers");
        end

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pov_display.f */
source/pov_pkg.sv
source/spi_slave.sv
source/spi_decoder.sv
source/clock_enable.sv
source/framebuffer_emulator.sv
source/driver_controller.sv
source/pov_display.sv
tb/pov_display_tb.sv

/* run.sh */
#!/bin/sh
# Builds the POV display testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f pov_display.f --top-module pov_display_tb -o pov_display_sim

# The simulator exits non-zero on $fatal, the verdict comes from its output
output=$(./obj_dir/pov_display_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
